// ==== ipic_cfg_pkg.sv ====
// Line count must be a power of two between 2 and 32 so the void vector sets the top CISV bit
package ipic_cfg_pkg;

    // ----------------------------------------
    // Defaults
    // ----------------------------------------
    localparam int IPIC_N_LINES     = 16;   // Interrupt lines
    localparam int IPIC_SYNC_STAGES = 2;    // Synchronizer depth, always two

    // ----------------------------------------
    // Derived widths
    // ----------------------------------------

    // Bits to number one line
    function automatic int ipic_idx_w(input int n);
        return $clog2(n);
    endfunction

    // CISV width, one bit more than the index
    function automatic int ipic_vect_w(input int n);
        return $clog2(n) + 1;
    endfunction

    // Vector number meaning nothing in service
    function automatic int ipic_void_vect(input int n);
        return n;
    endfunction

endpackage

// ==== ipic_regmap_pkg.sv ====
// Register map for a 3-bit CSR window with 32-bit data; address 1 is reserved and reads zero
package ipic_regmap_pkg;

    // ----------------------------------------
    // Bus
    // ----------------------------------------
    localparam int IPIC_XLEN = 32;          // CSR data width

    typedef logic [2:0] ipic_addr_t;        // Register window

    // ----------------------------------------
    // Register addresses
    // ----------------------------------------
    localparam ipic_addr_t IPIC_CISV = 3'd0;    // Current vector in service, read only
    // Address 1 held the current line CSR, now reserved
    localparam ipic_addr_t IPIC_IPR  = 3'd2;    // Pending, write 1 to clear
    localparam ipic_addr_t IPIC_ISVR = 3'd3;    // In service, read only
    localparam ipic_addr_t IPIC_EOI  = 3'd4;    // End of interrupt, any data
    localparam ipic_addr_t IPIC_SOI  = 3'd5;    // Start of interrupt, any data
    localparam ipic_addr_t IPIC_IDX  = 3'd6;    // Line shown through ICSR
    localparam ipic_addr_t IPIC_ICSR = 3'd7;    // Control and status of IDX line

    // ----------------------------------------
    // ICSR fields
    // ----------------------------------------
    localparam int ICSR_IP     = 0;     // Pending, write 1 to clear
    localparam int ICSR_IE     = 1;     // Enable
    localparam int ICSR_IM     = 2;     // Mode, 0 level and 1 edge
    localparam int ICSR_INV    = 3;     // Invert line
    localparam int ICSR_IS     = 4;     // In service, read only
    localparam int ICSR_LN_LSB = 12;    // Line number field, read only

endpackage

// ==== ipic_prio_find.sv ====
// Pure combinational search; inputs above n_lines are padded to the next power of two as zero
`timescale 1ns/1ns

module ipic_prio_find
    import ipic_cfg_pkg::*;
#(
    parameter int n_lines = IPIC_N_LINES
) (
    input  logic [n_lines-1:0]             vec_i,      // Candidate lines
    output logic                           found_o,    // Some bit set
    output logic [ipic_idx_w(n_lines)-1:0] idx_o       // Lowest set bit
);

    localparam int idx_w = ipic_idx_w(n_lines);
    localparam int n_pad = 1 << idx_w;     // Leaves of the tree

    // Tree nodes, level 0 are the leaves
    logic [n_pad-1:0] node_vd [idx_w+1];
    logic [idx_w-1:0] node_ix [idx_w+1][n_pad];

    // ----------------------------------------
    // Pairwise stages
    // ----------------------------------------
    always_comb begin
        node_vd[0] = n_pad'(vec_i);
        for (int i = 0; i < n_pad; i++) begin
            node_ix[0][i] = '0;     // Leaf carries no index bits
        end
        for (int l = 1; l <= idx_w; l++) begin
            node_vd[l] = '0;
            for (int i = 0; i < n_pad; i++) begin
                node_ix[l][i] = '0;
            end
            for (int i = 0; i < (n_pad >> l); i++) begin
                node_vd[l][i] = node_vd[l-1][2*i] | node_vd[l-1][2*i+1];
                // Left child wins ties, lower index first
                node_ix[l][i] = node_vd[l-1][2*i] ? node_ix[l-1][2*i]
                                                  : node_ix[l-1][2*i+1];
                node_ix[l][i][l-1] = ~node_vd[l-1][2*i];   // Set when right half taken
            end
        end
    end

    assign found_o = node_vd[idx_w][0];     // Root
    assign idx_o   = node_ix[idx_w][0];

endmodule

// ==== ipic_pending.sv ====
// Lines are asynchronous and pass two flops; level mode uses the stored INV bit, not a pending write
`timescale 1ns/1ns

module ipic_pending
    import ipic_cfg_pkg::*;
#(
    parameter int n_lines = IPIC_N_LINES
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [n_lines-1:0] irq_lines_i,    // Raw interrupt lines
    input  logic [n_lines-1:0] imr_i,          // Mode, 1 for edge
    input  logic [n_lines-1:0] iinvr_i,        // Inversion
    input  logic [n_lines-1:0] clr_req_i,      // Clears from IPR and ICSR writes
    input  logic [n_lines-1:0] soi_clr_i,      // Clear of the line just started
    output logic [n_lines-1:0] ipr_o           // Pending flags
);

    logic [n_lines-1:0] sync_q [IPIC_SYNC_STAGES];  // Synchronizer chain
    logic [n_lines-1:0] lines;                      // Synchronized lines
    logic [n_lines-1:0] lines_dly;                  // One cycle older copy
    logic [n_lines-1:0] lvl;                        // Active level after inversion
    logic [n_lines-1:0] edge_det;                   // Change towards active level
    logic [n_lines-1:0] clr;                        // Clears allowed this cycle
    logic [n_lines-1:0] ipr_q;
    logic [n_lines-1:0] ipr_next;

    // ----------------------------------------
    // Synchronizer and edge detect
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < IPIC_SYNC_STAGES; s++) begin
                sync_q[s] <= '0;
            end
            lines_dly <= '0;
        end else begin
            sync_q[0] <= irq_lines_i;
            for (int s = 1; s < IPIC_SYNC_STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
            lines_dly <= lines;
        end
    end

    assign lines    = sync_q[IPIC_SYNC_STAGES-1];
    assign lvl      = lines ^ iinvr_i;
    assign edge_det = (lines ^ lines_dly) & lvl;    // Any change that lands active

    // ----------------------------------------
    // Pending register
    // ----------------------------------------

    // Level lines can only be cleared once inactive
    assign clr = (clr_req_i | soi_clr_i) & (~lvl | imr_i);

    always_comb begin
        for (int i = 0; i < n_lines; i++) begin
            if (clr[i]) begin
                ipr_next[i] = 1'b0;
            end else if (!imr_i[i]) begin
                ipr_next[i] = lvl[i];                   // Level follows line
            end else begin
                ipr_next[i] = ipr_q[i] | edge_det[i];   // Edge is sticky
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ipr_q <= '0;
        end else begin
            ipr_q <= ipr_next;
        end
    end

    assign ipr_o = ipr_q;

endmodule

// ==== ipic_csr.sv ====
// Single-cycle strobes without stall; reads are combinational and zero when r_req_i is low
`timescale 1ns/1ns

module ipic_csr
    import ipic_cfg_pkg::*;
    import ipic_regmap_pkg::*;
#(
    parameter int n_lines = IPIC_N_LINES
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            r_req_i,     // Read strobe
    input  logic                            w_req_i,     // Write strobe
    input  ipic_addr_t                      addr_i,
    input  logic [IPIC_XLEN-1:0]            wdata_i,
    input  logic [n_lines-1:0]              ipr_i,       // Pending flags
    input  logic [n_lines-1:0]              isvr_i,      // In service flags
    input  logic [ipic_vect_w(n_lines)-1:0] cisv_i,      // Current vector
    output logic [IPIC_XLEN-1:0]            rdata_o,
    output logic [n_lines-1:0]              ier_o,       // Enables
    output logic [n_lines-1:0]              imr_o,       // Modes
    output logic [n_lines-1:0]              iinvr_o,     // Inversions
    output logic [n_lines-1:0]              clr_req_o,   // Pending clear requests
    output logic                            eoi_wr_o,    // EOI written
    output logic                            soi_wr_o     // SOI written
);

    localparam int idx_w = ipic_idx_w(n_lines);

    logic             idx_wr;
    logic             icsr_wr;
    logic             ipr_wr;
    logic [idx_w-1:0] idx_q;        // Line selected for ICSR
    logic [n_lines-1:0] ier_q;
    logic [n_lines-1:0] imr_q;
    logic [n_lines-1:0] iinvr_q;

    // ----------------------------------------
    // Write decode
    // ----------------------------------------
    always_comb begin
        eoi_wr_o = 1'b0;
        soi_wr_o = 1'b0;
        idx_wr   = 1'b0;
        icsr_wr  = 1'b0;
        ipr_wr   = 1'b0;
        if (w_req_i) begin
            case (addr_i)
                IPIC_IPR:  ipr_wr   = 1'b1;
                IPIC_EOI:  eoi_wr_o = 1'b1;
                IPIC_SOI:  soi_wr_o = 1'b1;
                IPIC_IDX:  idx_wr   = 1'b1;
                IPIC_ICSR: icsr_wr  = 1'b1;
                default:   ;        // CISV, ISVR and reserved ignore writes
            endcase
        end
    end

    // ----------------------------------------
    // IDX and per-line control
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q   <= '0;
            ier_q   <= '0;
            imr_q   <= '0;
            iinvr_q <= '0;
        end else begin
            if (idx_wr) begin
                idx_q <= wdata_i[idx_w-1:0];
            end
            if (icsr_wr) begin    // Only the IDX line changes
                ier_q[idx_q]   <= wdata_i[ICSR_IE];
                imr_q[idx_q]   <= wdata_i[ICSR_IM];
                iinvr_q[idx_q] <= wdata_i[ICSR_INV];
            end
        end
    end

    assign ier_o   = ier_q;
    assign imr_o   = imr_q;
    assign iinvr_o = iinvr_q;

    // Pending clears, filtered by line state in the pending block
    always_comb begin
        clr_req_o = '0;
        if (ipr_wr) begin
            clr_req_o = wdata_i[n_lines-1:0];
        end else if (icsr_wr) begin
            clr_req_o[idx_q] = wdata_i[ICSR_IP];
        end
    end

    // ----------------------------------------
    // Read multiplexer
    // ----------------------------------------
    always_comb begin
        rdata_o = '0;
        if (r_req_i) begin
            case (addr_i)
                IPIC_CISV: rdata_o = IPIC_XLEN'(cisv_i);
                IPIC_IPR:  rdata_o = IPIC_XLEN'(ipr_i);
                IPIC_ISVR: rdata_o = IPIC_XLEN'(isvr_i);
                IPIC_IDX:  rdata_o = IPIC_XLEN'(idx_q);
                IPIC_ICSR: begin
                    rdata_o[ICSR_IP]  = ipr_i[idx_q];
                    rdata_o[ICSR_IE]  = ier_q[idx_q];
                    rdata_o[ICSR_IM]  = imr_q[idx_q];
                    rdata_o[ICSR_INV] = iinvr_q[idx_q];
                    rdata_o[ICSR_IS]  = isvr_i[idx_q];
                    rdata_o[ICSR_LN_LSB +: idx_w] = idx_q;     // Echo of line number
                end
                default: rdata_o = '0;     // EOI, SOI and reserved read zero
            endcase
        end
    end

endmodule

// ==== ipic_service.sv ====
// Lower index wins; SOI only acts while the request is high, EOI only while a line is in service
`timescale 1ns/1ns

module ipic_service
    import ipic_cfg_pkg::*;
#(
    parameter int n_lines = IPIC_N_LINES
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [n_lines-1:0]              ipr_i,        // Pending flags
    input  logic [n_lines-1:0]              ier_i,        // Enables
    input  logic                            eoi_wr_i,
    input  logic                            soi_wr_i,
    output logic                            irq_m_req_o,  // Machine interrupt to core
    output logic [n_lines-1:0]              soi_clr_o,    // One-hot pending clear
    output logic [n_lines-1:0]              isvr_o,
    output logic [ipic_vect_w(n_lines)-1:0] cisv_o
);

    localparam int idx_w  = ipic_idx_w(n_lines);
    localparam int vect_w = ipic_vect_w(n_lines);
    localparam logic [vect_w-1:0] void_vect = vect_w'(ipic_void_vect(n_lines));

    logic [n_lines-1:0] req_v;      // Pending and enabled
    logic               req_vd;
    logic [idx_w-1:0]   req_idx;    // Best candidate
    logic               serv_vd;    // Something in service
    logic [idx_w-1:0]   serv_idx;
    logic [n_lines-1:0] isvr_eoi;   // ISVR without current line
    logic               eoi_vd;
    logic [idx_w-1:0]   eoi_idx;    // Line to resume after EOI
    logic               irq_req;
    logic               start;
    logic               eoi;
    logic [n_lines-1:0] isvr_q;
    logic [vect_w-1:0]  cisv_q;

    // ----------------------------------------
    // Priority search
    // ----------------------------------------
    assign req_v = ipr_i & ier_i;

    ipic_prio_find #(
        .n_lines (n_lines)
    ) req_find_inst (
        .vec_i   (req_v),
        .found_o (req_vd),
        .idx_o   (req_idx)
    );

    // Void vector has the top bit set
    assign serv_vd  = ~cisv_q[vect_w-1];
    assign serv_idx = cisv_q[idx_w-1:0];

    always_comb begin
        isvr_eoi = isvr_q;
        if (serv_vd) begin
            isvr_eoi[serv_idx] = 1'b0;
        end
    end

    ipic_prio_find #(
        .n_lines (n_lines)
    ) eoi_find_inst (
        .vec_i   (isvr_eoi),
        .found_o (eoi_vd),
        .idx_o   (eoi_idx)
    );

    // Request only if idle or the candidate outranks CISV
    assign irq_req = req_vd & (~serv_vd | (req_idx < serv_idx));
    assign start   = soi_wr_i & irq_req;
    assign eoi     = eoi_wr_i & serv_vd;

    // ----------------------------------------
    // ISVR and CISV
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            isvr_q <= '0;
            cisv_q <= void_vect;
        end else if (start) begin
            isvr_q[req_idx] <= 1'b1;    // Nest the new line
            cisv_q          <= {1'b0, req_idx};
        end else if (eoi) begin
            isvr_q <= isvr_eoi;
            cisv_q <= eoi_vd ? {1'b0, eoi_idx} : void_vect;   // Resume outer line
        end
    end

    always_comb begin
        soi_clr_o = '0;
        if (start) begin
            soi_clr_o[req_idx] = 1'b1;
        end
    end

    assign irq_m_req_o = irq_req;
    assign isvr_o      = isvr_q;
    assign cisv_o      = cisv_q;

endmodule

// ==== ipic_top.sv ====
// CSR strobes are one cycle with no handshake; irq_lines_i may be asynchronous to clk
`timescale 1ns/1ns

module ipic_top
    import ipic_cfg_pkg::*;
    import ipic_regmap_pkg::*;
#(
    parameter int n_lines = IPIC_N_LINES
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [n_lines-1:0]   irq_lines_i,    // External interrupt lines
    input  logic                 r_req_i,        // CSR read strobe
    input  logic                 w_req_i,        // CSR write strobe
    input  ipic_addr_t           addr_i,
    input  logic [IPIC_XLEN-1:0] wdata_i,
    output logic [IPIC_XLEN-1:0] rdata_o,
    output logic                 irq_m_req_o     // To core
);

    localparam int vect_w = ipic_vect_w(n_lines);

    // ----------------------------------------
    // Block wires
    // ----------------------------------------
    logic [n_lines-1:0] imr;
    logic [n_lines-1:0] iinvr;
    logic [n_lines-1:0] ier;
    logic [n_lines-1:0] clr_req;
    logic [n_lines-1:0] ipr;
    logic [n_lines-1:0] soi_clr;
    logic [n_lines-1:0] isvr;
    logic [vect_w-1:0]  cisv;
    logic               eoi_wr;
    logic               soi_wr;

    ipic_pending #(
        .n_lines (n_lines)
    ) ipic_pending_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_lines_i (irq_lines_i),
        .imr_i       (imr),
        .iinvr_i     (iinvr),
        .clr_req_i   (clr_req),
        .soi_clr_i   (soi_clr),
        .ipr_o       (ipr)
    );

    ipic_csr #(
        .n_lines (n_lines)
    ) ipic_csr_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .r_req_i   (r_req_i),
        .w_req_i   (w_req_i),
        .addr_i    (addr_i),
        .wdata_i   (wdata_i),
        .ipr_i     (ipr),
        .isvr_i    (isvr),
        .cisv_i    (cisv),
        .rdata_o   (rdata_o),
        .ier_o     (ier),
        .imr_o     (imr),
        .iinvr_o   (iinvr),
        .clr_req_o (clr_req),
        .eoi_wr_o  (eoi_wr),
        .soi_wr_o  (soi_wr)
    );

    ipic_service #(
        .n_lines (n_lines)
    ) ipic_service_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .ipr_i       (ipr),
        .ier_i       (ier),
        .eoi_wr_i    (eoi_wr),
        .soi_wr_i    (soi_wr),
        .irq_m_req_o (irq_m_req_o),
        .soi_clr_o   (soi_clr),
        .isvr_o      (isvr),
        .cisv_o      (cisv)
    );

endmodule

// ==== tb_ipic_tests.svh ====
// Test tasks for tb_ipic; included inside the module and relies on its signals and helpers
`ifndef TB_IPIC_TESTS_SVH
`define TB_IPIC_TESTS_SVH

    // Lines low, all control off, pending cleared
    task automatic quiesce();
        int i;
        drive_lines('0);
        idle_cycles(3);
        for (i = 0; i < n_lines; i++) begin
            configure_line(i, 1'b0, 1'b0, 1'b0);
        end
        csr_write(IPIC_IPR, IPIC_XLEN'({n_lines{1'b1}}));
        expect_reg(IPIC_IPR, "IPR", '0);
    endtask

    task automatic test_reset();
        check_eq("rdata_o", rdata, '0);     // No read strobe
        expect_reg(IPIC_CISV, "CISV", void_vect);
        expect_reg(IPIC_IPR, "IPR", '0);
        expect_reg(IPIC_ISVR, "ISVR", '0);
        expect_reg(IPIC_IDX, "IDX", '0);
        expect_reg(IPIC_ICSR, "ICSR", '0);
        check_eq("irq_m_req_o", IPIC_XLEN'(irq_m_req), '0);
    endtask

    task automatic test_level();
        int ln;
        ln = $urandom % n_lines;
        configure_line(ln, 1'b1, 1'b0, 1'b0);
        expect_reg(IPIC_ICSR, "ICSR", icsr_word(ln, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
        drive_lines(line_bit(ln));
        wait_req(1'b1, 3);                      // Two sync edges plus pending edge
        expect_reg(IPIC_IPR, "IPR", IPIC_XLEN'(line_bit(ln)));
        expect_reg(IPIC_ICSR, "ICSR", icsr_word(ln, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0));
        drive_lines('0);
        wait_req(1'b0, 3);
        expect_reg(IPIC_IPR, "IPR", '0);        // Level follows line
        quiesce();
    endtask

    task automatic test_inversion();
        configure_line(5, 1'b1, 1'b0, 1'b1);    // Active low
        wait_req(1'b1, 3);
        expect_reg(IPIC_IPR, "IPR", IPIC_XLEN'(line_bit(5)));
        // IP clear while still active must not stick
        csr_write(IPIC_ICSR, icsr_word(5, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0));
        check_eq("irq_m_req_o", IPIC_XLEN'(irq_m_req), 32'h1);     // Held through write edge
        expect_reg(IPIC_IPR, "IPR", IPIC_XLEN'(line_bit(5)));
        expect_reg(IPIC_ICSR, "ICSR", icsr_word(5, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0));
        drive_lines(line_bit(5));               // High is inactive here
        wait_req(1'b0, 3);
        expect_reg(IPIC_IPR, "IPR", '0);
        quiesce();
    endtask

    task automatic test_edge();
        configure_line(9, 1'b1, 1'b1, 1'b0);
        drive_lines(line_bit(9));
        wait_req(1'b1, 3);
        idle_cycles(2);                         // Short pulse
        drive_lines('0);
        idle_cycles(4);
        check_eq("irq_m_req_o", IPIC_XLEN'(irq_m_req), 32'h1);     // Sticky
        expect_reg(IPIC_IPR, "IPR", IPIC_XLEN'(line_bit(9)));
        csr_write(IPIC_IPR, IPIC_XLEN'(line_bit(9)));
        wait_req(1'b0, 1);
        expect_reg(IPIC_IPR, "IPR", '0);
        quiesce();
    endtask

    task automatic test_nesting();
        int hi;         // Nested on top
        int mid;        // Started first
        int lo;         // Left pending
        hi  = $urandom % 5;
        mid = 5 + $urandom % 5;
        lo  = 10 + $urandom % 6;
        configure_line(hi, 1'b1, 1'b1, 1'b0);
        configure_line(mid, 1'b1, 1'b1, 1'b0);
        configure_line(lo, 1'b1, 1'b1, 1'b0);
        drive_lines(line_bit(mid) | line_bit(lo));
        wait_req(1'b1, 3);
        expect_reg(IPIC_IPR, "IPR", IPIC_XLEN'(line_bit(mid) | line_bit(lo)));
        csr_write(IPIC_SOI, '0);
        expect_reg(IPIC_CISV, "CISV", IPIC_XLEN'(mid));
        expect_reg(IPIC_ISVR, "ISVR", IPIC_XLEN'(line_bit(mid)));
        expect_reg(IPIC_IPR, "IPR", IPIC_XLEN'(line_bit(lo)));
        check_eq("irq_m_req_o", IPIC_XLEN'(irq_m_req), '0);         // lo ranks below mid
        drive_lines(line_bit(mid) | line_bit(lo) | line_bit(hi));
        wait_req(1'b1, 3);
        csr_write(IPIC_SOI, '0);
        expect_reg(IPIC_CISV, "CISV", IPIC_XLEN'(hi));
        expect_reg(IPIC_ISVR, "ISVR", IPIC_XLEN'(line_bit(mid) | line_bit(hi)));
        expect_reg(IPIC_IPR, "IPR", IPIC_XLEN'(line_bit(lo)));
        csr_write(IPIC_IDX, IPIC_XLEN'(mid));
        expect_reg(IPIC_ICSR, "ICSR", icsr_word(mid, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1));
        csr_write(IPIC_EOI, '0);
        expect_reg(IPIC_CISV, "CISV", IPIC_XLEN'(mid));             // Back to outer line
        expect_reg(IPIC_ISVR, "ISVR", IPIC_XLEN'(line_bit(mid)));
        csr_write(IPIC_EOI, '0);
        expect_reg(IPIC_CISV, "CISV", void_vect);
        expect_reg(IPIC_ISVR, "ISVR", '0);
        check_eq("irq_m_req_o", IPIC_XLEN'(irq_m_req), 32'h1);      // lo still waiting
        quiesce();
    endtask

    task automatic test_blocking();
        configure_line(3, 1'b1, 1'b1, 1'b0);
        configure_line(12, 1'b1, 1'b1, 1'b0);
        drive_lines(line_bit(3));
        wait_req(1'b1, 3);
        csr_write(IPIC_SOI, '0);
        expect_reg(IPIC_CISV, "CISV", 32'h3);
        drive_lines(line_bit(3) | line_bit(12));
        idle_cycles(4);
        check_eq("irq_m_req_o", IPIC_XLEN'(irq_m_req), '0);         // Blocked by line 3
        expect_reg(IPIC_IPR, "IPR", IPIC_XLEN'(line_bit(12)));
        csr_write(IPIC_SOI, '0);                // No request, no effect
        expect_reg(IPIC_CISV, "CISV", 32'h3);
        expect_reg(IPIC_ISVR, "ISVR", IPIC_XLEN'(line_bit(3)));
        expect_reg(IPIC_IPR, "IPR", IPIC_XLEN'(line_bit(12)));
        csr_write(IPIC_EOI, '0);
        expect_reg(IPIC_CISV, "CISV", void_vect);
        wait_req(1'b1, 1);                      // Line 12 now free to request
        quiesce();
    endtask

`endif

// ==== tb_ipic.sv ====
// Directed testbench for ipic_top at the default line count; timing bounds assume two sync flops
`timescale 1ns/1ns

module tb_ipic
    import ipic_cfg_pkg::*;
    import ipic_regmap_pkg::*;
();

    localparam int n_lines = IPIC_N_LINES;
    localparam logic [IPIC_XLEN-1:0] void_vect = IPIC_XLEN'(n_lines);   // Nothing in service

    logic                 clk;
    logic                 rst_n;
    logic [n_lines-1:0]   irq_lines;
    logic                 r_req;
    logic                 w_req;
    ipic_addr_t           addr;
    logic [IPIC_XLEN-1:0] wdata;
    logic [IPIC_XLEN-1:0] rdata;
    logic                 irq_m_req;
    int                   errors;
    int                   checks;

    ipic_top #(
        .n_lines (n_lines)
    ) ipic_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_lines_i (irq_lines),
        .r_req_i     (r_req),
        .w_req_i     (w_req),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .rdata_o     (rdata),
        .irq_m_req_o (irq_m_req)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    // ----------------------------------------
    // Checks and bus access
    // ----------------------------------------
    task automatic check_eq(input string name, input logic [IPIC_XLEN-1:0] got,
                            input logic [IPIC_XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic csr_write(input ipic_addr_t a, input logic [IPIC_XLEN-1:0] d);
        @(posedge clk);
        #2;
        w_req = 1'b1;
        addr  = a;
        wdata = d;
        @(posedge clk);     // Write lands on this edge
        #2;
        w_req = 1'b0;
    endtask

    task automatic csr_read(input ipic_addr_t a, output logic [IPIC_XLEN-1:0] d);
        @(posedge clk);
        #2;
        r_req = 1'b1;
        addr  = a;
        #8;
        d = rdata;          // Same-cycle data
        @(posedge clk);
        #2;
        r_req = 1'b0;
    endtask

    task automatic expect_reg(input ipic_addr_t a, input string name,
                              input logic [IPIC_XLEN-1:0] exp);
        logic [IPIC_XLEN-1:0] d;
        csr_read(a, d);
        check_eq(name, d, exp);
    endtask

    // ----------------------------------------
    // Line helpers
    // ----------------------------------------
    function automatic logic [n_lines-1:0] line_bit(input int ln);
        return n_lines'(1) << ln;
    endfunction

    // Expected ICSR word, line number echoed from bit 12
    function automatic logic [IPIC_XLEN-1:0] icsr_word(input int ln, input logic ip,
        input logic ie, input logic im, input logic inv, input logic in_svc);
        logic [IPIC_XLEN-1:0] w;
        w = IPIC_XLEN'(ln) << ICSR_LN_LSB;
        w[ICSR_IP]  = ip;
        w[ICSR_IE]  = ie;
        w[ICSR_IM]  = im;
        w[ICSR_INV] = inv;
        w[ICSR_IS]  = in_svc;
        return w;
    endfunction

    task automatic drive_lines(input logic [n_lines-1:0] v);
        @(posedge clk);
        #2;
        irq_lines = v;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #10;                // Mid cycle sample point
    endtask

    task automatic configure_line(input int ln, input logic ie, input logic im, input logic inv);
        csr_write(IPIC_IDX, IPIC_XLEN'(ln));
        csr_write(IPIC_ICSR, icsr_word(ln, 1'b0, ie, im, inv, 1'b0));
    endtask

    // Bounded wait on the request output
    task automatic wait_req(input logic level, input int max_edges);
        int  n;
        bit  done;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            if (irq_m_req === level) begin
                done = 1'b1;
            end else if (n == max_edges) begin
                errors++;
                $display("Timeout: irq_m_req_o did not become %0b within %0d clock edges",
                         level, max_edges);
                done = 1'b1;
            end else begin
                @(posedge clk);
                #10;
                n++;
            end
        end
    endtask

    `include "tb_ipic_tests.svh"

    // ----------------------------------------
    // Sequence and report
    // ----------------------------------------
    initial begin
        errors    = 0;
        checks    = 0;
        rst_n     = 1'b0;
        irq_lines = '0;
        r_req     = 1'b0;
        w_req     = 1'b0;
        addr      = '0;
        wdata     = '0;
        void'($urandom(27));            // Fixed seed for line picks
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset();
        test_level();
        test_inversion();
        test_edge();
        test_nesting();
        test_blocking();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+.
ipic_cfg_pkg.sv
ipic_regmap_pkg.sv
ipic_prio_find.sv
ipic_pending.sv
ipic_csr.sv
ipic_service.sv
ipic_top.sv
tb_ipic.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the interrupt controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ns -f tb.f --top-module tb_ipic -o tb_ipic_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_ipic_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
exit 0
